/* cpu_pkg.sv */
package cpu_pkg;

    parameter int ADDR_WIDTH     = 32;
    parameter int DATA_WIDTH     = 32;
    parameter int FETCH_WIDTH    = 2;  // Words per fetch packet and buffer ports per side
    parameter int REG_ADDR_WIDTH = 5;

    // LoongArch major opcodes
    parameter logic [9:0]  OPC_ADDI_W = 10'b0000001010;
    parameter logic [16:0] OPC_ADD_W  = 17'b00000000000100000;
    parameter logic [5:0]  OPC_B      = 6'b010100;

    // ADD.W and friends
    typedef struct packed {
        logic [16:0]               opcode17;
        logic [REG_ADDR_WIDTH-1:0] rk;
        logic [REG_ADDR_WIDTH-1:0] rj;
        logic [REG_ADDR_WIDTH-1:0] rd;
    } fmt_3r_t;

    // ADDI.W
    typedef struct packed {
        logic [9:0]                opcode10;
        logic [11:0]               si12;
        logic [REG_ADDR_WIDTH-1:0] rj;
        logic [REG_ADDR_WIDTH-1:0] rd;
    } fmt_2ri12_t;

    // B, offset is split with the high part at the bottom
    typedef struct packed {
        logic [5:0]  opcode6;
        logic [15:0] offs_lo16;
        logic [9:0]  offs_hi10;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_i26_t   i26;
    } instr_u;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc;
        instr_u                instr;
    } ib_slot_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] target;
    } redirect_t;

    // Retired instruction, same fields as the debug write-back port
    typedef struct packed {
        logic                      valid;
        logic [ADDR_WIDTH-1:0]     pc;
        logic                      rf_wen;
        logic [REG_ADDR_WIDTH-1:0] rf_wnum;
        logic [DATA_WIDTH-1:0]     rf_wdata;
    } commit_t;

endpackage

/* regs_file.sv */
module regs_file (
    input  logic                                                          clk,
    input  logic                                                          reset_i,
    input  logic [2*cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::REG_ADDR_WIDTH-1:0] raddr_i,
    output logic [2*cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::DATA_WIDTH-1:0]     rdata_o,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0]                                we_i,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::REG_ADDR_WIDTH-1:0]   waddr_i,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][cpu_pkg::DATA_WIDTH-1:0]       wdata_i
);

    localparam int FW = cpu_pkg::FETCH_WIDTH;

    logic [cpu_pkg::DATA_WIDTH-1:0] regs [2**cpu_pkg::REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < 2**cpu_pkg::REG_ADDR_WIDTH; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later port wins on the same register
            for (int i = 0; i < FW; i++) begin
                if (we_i[i] && waddr_i[i] != '0) begin  // r0 stays zero
                    regs[waddr_i[i]] <= wdata_i[i];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2 * FW; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
        end
    end

endmodule

/* fetch_unit.sv */
module fetch_unit #(
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                                     clk,
    input  logic                                     reset_i,
    input  logic                                     stall_req_i,
    input  cpu_pkg::redirect_t                       redirect_i,
    output logic                                     imem_req_o,
    output logic [cpu_pkg::ADDR_WIDTH-1:0]           imem_addr_o,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][31:0]    imem_data_i,
    output cpu_pkg::ib_slot_t                        fetch_slots_o [cpu_pkg::FETCH_WIDTH]
);

    localparam int AW     = cpu_pkg::ADDR_WIDTH;
    localparam int FW     = cpu_pkg::FETCH_WIDTH;
    localparam int SLOT_W = $clog2(FW);
    localparam logic [AW-1:0] ALIGN_MASK = ~AW'(FW * 4 - 1);

    logic [AW-1:0]     pc_q;         // Aligned packet address
    logic [SLOT_W-1:0] first_q;      // First wanted word in the packet at pc_q
    logic              run_q;
    logic              req_q;        // Request outstanding, data arrives this cycle
    logic              stale_q;      // Redirect seen since that request
    logic [AW-1:0]     req_pc_q;
    logic [SLOT_W-1:0] req_first_q;

    assign imem_req_o  = run_q & ~stall_req_i;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q   <= 1'b0;
            req_q   <= 1'b0;
            stale_q <= 1'b0;
            pc_q    <= RESET_PC & ALIGN_MASK;
            first_q <= RESET_PC[SLOT_W+1:2];
        end else begin
            run_q   <= 1'b1;
            req_q   <= imem_req_o;
            stale_q <= redirect_i.valid;
            if (redirect_i.valid) begin
                pc_q    <= redirect_i.target & ALIGN_MASK;
                first_q <= redirect_i.target[SLOT_W+1:2]; // Target may sit mid-packet
            end else if (imem_req_o) begin
                pc_q    <= pc_q + AW'(FW * 4);
                first_q <= '0;
            end
        end
    end

    // Remember where the outstanding packet came from
    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            req_pc_q    <= pc_q;
            req_first_q <= first_q;
        end
    end

    always_comb begin
        for (int i = 0; i < FW; i++) begin
            fetch_slots_o[i].valid = req_q & ~stale_q & (SLOT_W'(i) >= req_first_q);
            fetch_slots_o[i].pc    = req_pc_q + AW'(4 * i);
            fetch_slots_o[i].instr = imem_data_i[i];  // Lower word is slot 0
        end
    end

endmodule

/* instr_buffer.sv */
module instr_buffer #(
    parameter int IB_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                flush_i,
    input  cpu_pkg::ib_slot_t                   fetch_slots_i [cpu_pkg::FETCH_WIDTH],
    output logic                                stall_req_o,
    output cpu_pkg::ib_slot_t                   head_slots_o [cpu_pkg::FETCH_WIDTH],
    input  logic [cpu_pkg::FETCH_WIDTH-1:0]     accept_i
);

    localparam int FW    = cpu_pkg::FETCH_WIDTH;
    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    cpu_pkg::ib_slot_t mem [IB_DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [PTR_W-1:0] wr_idx [FW];
    logic [CNT_W-1:0] n_in;
    logic [CNT_W-1:0] n_out;

    // Valid incoming slots go to consecutive entries
    always_comb begin
        n_in  = '0;
        n_out = '0;
        for (int i = 0; i < FW; i++) begin
            wr_idx[i] = tail_q + n_in[PTR_W-1:0];
            n_in      = n_in + CNT_W'(fetch_slots_i[i].valid);
            n_out     = n_out + CNT_W'(accept_i[i]);  // Accept is a prefix mask
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < FW; i++) begin
            if (fetch_slots_i[i].valid && !flush_i) begin
                mem[wr_idx[i]] <= fetch_slots_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + n_out[PTR_W-1:0];
            tail_q  <= tail_q + n_in[PTR_W-1:0];
            count_q <= count_q + n_in - n_out;
        end
    end

    always_comb begin
        for (int j = 0; j < FW; j++) begin
            head_slots_o[j]       = mem[head_q + PTR_W'(j)];
            head_slots_o[j].valid = count_q > CNT_W'(j);
        end
    end

    // Leave room for the packet returning now and the one requested now
    assign stall_req_o = count_q > CNT_W'(IB_DEPTH - 2 * FW);

endmodule

/* issue_unit.sv */
module issue_unit (
    input  logic                                clk,
    input  logic                                reset_i,
    input  cpu_pkg::ib_slot_t                   head_slots_i [cpu_pkg::FETCH_WIDTH],
    output logic [cpu_pkg::FETCH_WIDTH-1:0]     accept_o,
    output cpu_pkg::redirect_t                  redirect_o,
    output cpu_pkg::commit_t                    commit_o [cpu_pkg::FETCH_WIDTH]
);

    localparam int FW  = cpu_pkg::FETCH_WIDTH;
    localparam int DW  = cpu_pkg::DATA_WIDTH;
    localparam int AW  = cpu_pkg::ADDR_WIDTH;
    localparam int RAW = cpu_pkg::REG_ADDR_WIDTH;

    logic [FW-1:0]             is_addi;
    logic [FW-1:0]             is_add;
    logic [FW-1:0]             is_b;
    logic [FW-1:0]             wen;
    logic [FW-1:0][RAW-1:0]    rj;
    logic [FW-1:0][RAW-1:0]    rk;
    logic [FW-1:0][RAW-1:0]    rd;
    logic [FW-1:0][DW-1:0]     result;
    logic [FW-1:0][AW-1:0]     target;
    logic [2*FW-1:0][RAW-1:0]  raddr;
    logic [2*FW-1:0][DW-1:0]   rdata;
    logic [FW-1:0]             rf_we;
    logic                      raw_hazard;
    logic                      dual_ok;

    always_comb begin
        for (int i = 0; i < FW; i++) begin
            is_addi[i] = head_slots_i[i].instr.ri12.opcode10 == cpu_pkg::OPC_ADDI_W;
            is_add[i]  = head_slots_i[i].instr.r3.opcode17 == cpu_pkg::OPC_ADD_W;
            is_b[i]    = head_slots_i[i].instr.i26.opcode6 == cpu_pkg::OPC_B;
            rj[i]      = head_slots_i[i].instr.ri12.rj;
            rk[i]      = head_slots_i[i].instr.r3.rk;
            rd[i]      = head_slots_i[i].instr.r3.rd;

            raddr[2*i]   = rj[i];  // Even port rj, odd port rk
            raddr[2*i+1] = rk[i];

            wen[i] = (is_addi[i] | is_add[i]) & (rd[i] != '0);  // Everything else is a no-op

            if (is_add[i]) begin
                result[i] = rdata[2*i] + rdata[2*i+1];
            end else begin
                result[i] = rdata[2*i] + {{(DW-12){head_slots_i[i].instr.ri12.si12[11]}},
                                          head_slots_i[i].instr.ri12.si12};
            end

            target[i] = head_slots_i[i].pc + {{(AW-28){head_slots_i[i].instr.i26.offs_hi10[9]}},
                                              head_slots_i[i].instr.i26.offs_hi10,
                                              head_slots_i[i].instr.i26.offs_lo16, 2'b00};
        end
    end

    // Slot 1 must not read what slot 0 writes
    assign raw_hazard = wen[0] && (((is_addi[1] || is_add[1]) && rj[1] == rd[0]) ||
                                   (is_add[1] && rk[1] == rd[0]));
    assign dual_ok = head_slots_i[0].valid && head_slots_i[1].valid && !is_b[0] && !raw_hazard;

    assign accept_o[0] = head_slots_i[0].valid;
    assign accept_o[1] = dual_ok;

    // At most one B per issue group since a B in slot 0 issues alone
    assign redirect_o.valid  = (accept_o[0] & is_b[0]) | (accept_o[1] & is_b[1]);
    assign redirect_o.target = is_b[0] ? target[0] : target[1];

    assign rf_we = accept_o & wen;

    regs_file u_regs_file (
        .clk     (clk),
        .reset_i (reset_i),
        .raddr_i (raddr),
        .rdata_o (rdata),
        .we_i    (rf_we),
        .waddr_i (rd),
        .wdata_i (result)
    );

    always_ff @(posedge clk) begin
        for (int i = 0; i < FW; i++) begin
            if (reset_i) begin
                commit_o[i].valid <= 1'b0;
            end else begin
                commit_o[i].valid <= accept_o[i];
            end
            commit_o[i].pc       <= head_slots_i[i].pc;
            commit_o[i].rf_wen   <= wen[i];
            commit_o[i].rf_wnum  <= wen[i] ? rd[i] : '0;
            commit_o[i].rf_wdata <= wen[i] ? result[i] : '0;
        end
    end

endmodule

/* cpu_frontback_top.sv */
module cpu_frontback_top #(
    parameter int                             IB_DEPTH = 8,
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    output logic                                  imem_req_o,
    output logic [cpu_pkg::ADDR_WIDTH-1:0]        imem_addr_o,
    input  logic [cpu_pkg::FETCH_WIDTH-1:0][31:0] imem_data_i,
    output cpu_pkg::commit_t                      commit_o [cpu_pkg::FETCH_WIDTH]
);

    logic                                stall_req;
    cpu_pkg::redirect_t                  redirect;
    cpu_pkg::ib_slot_t                   fetch_slots [cpu_pkg::FETCH_WIDTH];
    cpu_pkg::ib_slot_t                   head_slots [cpu_pkg::FETCH_WIDTH];
    logic [cpu_pkg::FETCH_WIDTH-1:0]     accept;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_req_i   (stall_req),
        .redirect_i    (redirect),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .fetch_slots_o (fetch_slots)
    );

    instr_buffer #(
        .IB_DEPTH (IB_DEPTH)
    ) u_instr_buffer (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (redirect.valid),  // B empties the queue
        .fetch_slots_i (fetch_slots),
        .stall_req_o   (stall_req),
        .head_slots_o  (head_slots),
        .accept_i      (accept)
    );

    issue_unit u_issue_unit (
        .clk          (clk),
        .reset_i      (reset_i),
        .head_slots_i (head_slots),
        .accept_o     (accept),
        .redirect_o   (redirect),
        .commit_o     (commit_o)
    );

endmodule

/* tb_cpu_frontback.sv */
module tb_cpu_frontback;
    timeunit 1ns;
    timeprecision 1ps;

    // LoongArch encodings, taken from the ISA manual
    localparam logic [9:0]  ADDI_OP   = 10'h00a;
    localparam logic [16:0] ADD_OP    = 17'h00020;
    localparam logic [5:0]  B_OP      = 6'h14;
    localparam int          MEM_WORDS = 256;

    logic                   clk;
    logic                   reset_i;
    logic                   imem_req_o;
    logic [31:0]            imem_addr_o;
    logic [1:0][31:0]       imem_data_i;
    cpu_pkg::commit_t       commit_o [2];

    logic [31:0]            prog [MEM_WORDS];
    cpu_pkg::commit_t       exp_q [$];        // Expected retirement order
    int                     prog_len;
    int                     cidx;
    int                     errors;
    int                     checks;
    int                     tests;
    int                     cycles;
    int                     budget = 40;      // Grows with every test
    integer                 seed = 32'hbcc1;
    logic                   checking;
    logic                   req_seen;
    logic [31:0]            addr_seen;

    cpu_frontback_top #(
        .IB_DEPTH (8),
        .RESET_PC (32'h0)
    ) i_dut (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .commit_o    (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory, answers a request in the following cycle
    initial begin
        imem_data_i = '0;
        forever begin
            @(negedge clk);
            req_seen  = imem_req_o;
            addr_seen = imem_addr_o;
            // Packet addresses are 8-byte aligned
            if (req_seen && checking) begin
                check_field("imem_addr_o[2:0]", 32'(addr_seen[2:0]), 32'd0);
            end
            @(posedge clk);
            #1;
            if (req_seen) begin
                imem_data_i = {prog[addr_seen[9:2] + 8'd1], prog[addr_seen[9:2]]};
            end
        end
    end

    function automatic logic [31:0] enc_addi(input int rd, input int rj, input int imm);
        return {ADDI_OP, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_add(input int rd, input int rj, input int rk);
        return {ADD_OP, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_b(input int offs);  // Offset in words
        return {B_OP, offs[15:0], offs[25:16]};
    endfunction

    function automatic void put_word(input logic [31:0] w);
        prog[prog_len[7:0]] = w;
        prog_len++;
    endfunction

    function automatic void clear_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            prog[a[7:0]] = 32'hfc00_0000 | (a << 2);  // Undefined opcode, tagged with address
        end
        prog_len = 0;
    endfunction

    function automatic int rand_below(input int limit);
        return int'({$random(seed)} % limit);
    endfunction

    // ISA model from PC 0 with zeroed registers, stops after the B to itself
    function automatic void build_expected();
        logic [31:0]      regs [32];
        logic [31:0]      pc;
        logic [31:0]      w;
        logic [31:0]      res;
        logic [25:0]      offs;
        logic             done;
        logic             writes;
        cpu_pkg::commit_t e;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        exp_q.delete();
        pc   = '0;
        done = 1'b0;
        for (int step = 0; step < 1000 && !done; step++) begin
            w      = prog[pc[9:2]];
            e      = '0;
            e.pc   = pc;
            writes = 1'b0;
            res    = '0;
            if (w[31:22] == ADDI_OP) begin
                res    = regs[w[9:5]] + {{20{w[21]}}, w[21:10]};
                writes = 1'b1;
            end else if (w[31:15] == ADD_OP) begin
                res    = regs[w[9:5]] + regs[w[14:10]];
                writes = 1'b1;
            end
            if (writes && w[4:0] != 5'd0) begin
                e.rf_wen     = 1'b1;
                e.rf_wnum    = w[4:0];
                e.rf_wdata   = res;
                regs[w[4:0]] = res;
            end
            if (w[31:26] == B_OP) begin
                offs = {w[9:0], w[25:10]};
                done = offs == '0;
                pc   = pc + {{4{offs[25]}}, offs, 2'b00};
            end else begin
                pc = pc + 32'd4;
            end
            exp_q.push_back(e);
        end
    endfunction

    task automatic check_field(input string sig, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else begin
            $display("ERROR at %0d ns: %s expected %h got %h", $time, sig, want, got);
            errors++;
        end
    endtask

    // Slot 0 is older, so it is walked first
    always @(negedge clk) begin
        if (checking) begin
            for (int s = 0; s < 2; s++) begin
                if (commit_o[s].valid && cidx < exp_q.size()) begin
                    check_field($sformatf("commit_o[%0d].pc", s), commit_o[s].pc, exp_q[cidx].pc);
                    check_field($sformatf("commit_o[%0d].rf_wen", s),
                                32'(commit_o[s].rf_wen), 32'(exp_q[cidx].rf_wen));
                    if (exp_q[cidx].rf_wen) begin
                        check_field($sformatf("commit_o[%0d].rf_wnum", s),
                                    32'(commit_o[s].rf_wnum), 32'(exp_q[cidx].rf_wnum));
                        check_field($sformatf("commit_o[%0d].rf_wdata", s),
                                    commit_o[s].rf_wdata, exp_q[cidx].rf_wdata);
                    end
                    checks++;
                    cidx++;
                end
            end
        end
    end

    task automatic run_test(input string name);
        int errs_before;
        build_expected();
        budget = budget + 30 * exp_q.size() + 20;
        @(posedge clk);
        #1 reset_i = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset_i = 1'b0;
        errs_before = errors;
        cidx        = 0;
        checking    = 1'b1;
        wait (cidx == exp_q.size());
        checking = 1'b0;
        tests++;
        $display("test %-8s %0d commits, %0d errors", name, exp_q.size(), errors - errs_before);
    endtask

    task automatic gen_random(input int n);
        int kind;
        int off;
        clear_program();
        for (int i = 0; i < n - 1; i++) begin
            kind = rand_below(5);
            if (kind < 2) begin
                put_word(enc_addi(rand_below(8), rand_below(8), rand_below(4096)));
            end else if (kind < 4) begin
                put_word(enc_add(rand_below(8), rand_below(8), rand_below(8)));
            end else begin
                off = 1 + rand_below(3);
                if (i + off > n - 1) begin
                    off = n - 1 - i;  // Stay inside the program
                end
                put_word(enc_b(off));
            end
        end
        put_word(enc_b(0));
    endtask

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, expected commits never arrived", cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset_i  = 1'b1;
        checking = 1'b0;
        errors   = 0;
        checks   = 0;
        tests    = 0;

        clear_program();
        for (int i = 1; i <= 12; i++) begin
            put_word(enc_addi(1, 1, i * 3 - 7));
        end
        put_word(enc_b(0));
        run_test("chain");

        clear_program();
        put_word(enc_addi(1, 0, 100));
        put_word(enc_addi(2, 0, -5));
        put_word(enc_addi(3, 0, 7));
        put_word(enc_addi(4, 0, 9));
        put_word(enc_add(5, 1, 2));
        put_word(enc_add(6, 3, 4));
        put_word(enc_addi(7, 1, 1));
        put_word(enc_add(8, 4, 3));
        put_word(enc_b(0));
        run_test("pairs");

        clear_program();
        put_word(enc_addi(1, 0, 1));
        put_word(enc_addi(2, 0, 2));
        put_word(enc_b(3));           // Lands on 0x14
        put_word(enc_addi(3, 0, 99));
        put_word(enc_addi(1, 1, 50));
        put_word(enc_add(4, 1, 2));
        put_word(enc_addi(5, 4, -1));
        put_word(enc_b(0));
        run_test("branch");

        clear_program();
        put_word(enc_addi(0, 0, 7));
        put_word(enc_addi(1, 0, 3));
        put_word(enc_add(0, 1, 1));
        put_word(enc_add(2, 0, 1));
        put_word(enc_addi(3, 0, -2));
        put_word(enc_b(0));
        run_test("r0");

        // Each one reads the previous result, so issue is single and the buffer fills
        clear_program();
        for (int i = 0; i < 60; i++) begin
            put_word(enc_addi(i % 7 + 1, (i + 6) % 7 + 1, i));
        end
        put_word(enc_b(0));
        run_test("long");

        for (int p = 0; p < 3; p++) begin
            gen_random(30);
            run_test("random");
        end

        $display("%0d tests, %0d commits checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
cpu_pkg.sv
regs_file.sv
fetch_unit.sv
instr_buffer.sv
issue_unit.sv
cpu_frontback_top.sv
tb_cpu_frontback.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu_frontback
FILELIST = all.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
